// File: pipeline_types_pkg.sv
package pipeline_types_pkg;

    // Datapath geometry
    localparam int DATA_WIDTH = 32;
    localparam int REG_COUNT  = 32;

    // Data or instruction word
    typedef logic [DATA_WIDTH-1:0] word_t;

    // Register index sized from the register count
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;

    // Shift amount covering every bit position of a word
    typedef logic [$clog2(DATA_WIDTH)-1:0] shamt_t;

    // Raw I-type immediate field
    typedef logic [15:0] imm_t;

endpackage

// File: pipeline_isa_pkg.sv
package pipeline_isa_pkg;

    // Primary opcodes in instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // SPECIAL funct codes in instr[5:0]
    // Shift group
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    // Arithmetic and logic group
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_LUI  = 4'd8
    } alu_op_e;

    // Shifter operations
    typedef enum logic [1:0] {
        SH_SLL = 2'd0,
        SH_SRL = 2'd1,
        SH_SRA = 2'd2
    } shift_op_e;

    // Which unit drives the EX result
    typedef enum logic {
        RES_ALU   = 1'b0,
        RES_SHIFT = 1'b1
    } res_sel_e;

endpackage

// File: instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
    import pipeline_types_pkg::*;
    import pipeline_isa_pkg::*;
(
    input  word_t     instr,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    output reg_addr_t rd_addr,
    output word_t     imm_ext,
    output logic      b_sel_imm,
    output alu_op_e   alu_op,
    output shift_op_e shift_op,
    output logic      shamt_from_reg,
    output shamt_t    shamt,
    output res_sel_e  res_sel
);

    // Raw instruction fields
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rd_field;
    imm_t       imm;

    // Opcode classes
    logic       is_itype;
    logic       zero_ext;

    assign opcode   = instr[31:26];
    assign funct    = instr[5:0];
    assign rs_addr  = instr[25:21];
    assign rt_addr  = instr[20:16];
    assign rd_field = instr[15:11];
    assign shamt    = instr[10:6];
    assign imm      = instr[15:0];

    // Kept I-types
    assign is_itype = opcode inside {OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    // Logical ops and LUI use the immediate zero-extended
    assign zero_ext = opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    assign imm_ext  = zero_ext ? {{(DATA_WIDTH-16){1'b0}}, imm}
                               : {{(DATA_WIDTH-16){imm[15]}}, imm};

    always_comb begin
        // Defaults give an add to $0 for anything not decoded below
        rd_addr        = '0;
        b_sel_imm      = 1'b0;
        alu_op         = ALU_ADD;
        shift_op       = SH_SLL;
        shamt_from_reg = 1'b0;
        res_sel        = RES_ALU;
        if (opcode == OP_SPECIAL) begin
            // R-types write rd
            rd_addr = rd_field;
            case (funct)
                FN_ADDU:         alu_op   = ALU_ADD;
                FN_SUBU:         alu_op   = ALU_SUB;
                FN_AND:          alu_op   = ALU_AND;
                FN_OR:           alu_op   = ALU_OR;
                FN_XOR:          alu_op   = ALU_XOR;
                FN_NOR:          alu_op   = ALU_NOR;
                FN_SLT:          alu_op   = ALU_SLT;
                FN_SLTU:         alu_op   = ALU_SLTU;
                FN_SLL, FN_SLLV: shift_op = SH_SLL;
                FN_SRL, FN_SRLV: shift_op = SH_SRL;
                FN_SRA, FN_SRAV: shift_op = SH_SRA;
                default:         rd_addr  = '0;
            endcase
            // Shift group takes the shifter result
            if (funct inside {FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV})
                res_sel = RES_SHIFT;
            // Variable forms shift by rs[4:0]
            shamt_from_reg = funct inside {FN_SLLV, FN_SRLV, FN_SRAV};
        end else if (is_itype) begin
            // I-types write rt with the immediate as operand B
            rd_addr   = rt_addr;
            b_sel_imm = 1'b1;
            case (opcode)
                OP_SLTI: alu_op = ALU_SLT;
                OP_ANDI: alu_op = ALU_AND;
                OP_ORI:  alu_op = ALU_OR;
                OP_XORI: alu_op = ALU_XOR;
                OP_LUI:  alu_op = ALU_LUI;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

endmodule

// File: gpr_file.sv
`timescale 1ns/1ps

module gpr_file
    import pipeline_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      w_en,
    input  reg_addr_t w_addr,
    input  word_t     w_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    // Entry 0 is hardwired to zero and not stored
    word_t regs [1:REG_COUNT-1];

    // Read port with write-through of the data retiring this cycle
    function automatic word_t read_port(input reg_addr_t addr);
        word_t value;
        if (addr == '0)
            value = '0;
        else if (w_en && (addr == w_addr))
            value = w_data;
        else
            value = regs[addr];
        return value;
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    // Write on the edge that completes a retire
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (w_en && (w_addr != '0)) begin
            regs[w_addr] <= w_data;
        end
    end

endmodule

// File: exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import pipeline_types_pkg::*;
    import pipeline_isa_pkg::*;
(
    input  word_t     op_a,
    input  word_t     op_b,
    input  word_t     imm_ext,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      b_sel_imm,
    input  logic      shamt_from_reg,
    input  shamt_t    shamt,
    input  alu_op_e   alu_op,
    input  shift_op_e shift_op,
    input  res_sel_e  res_sel,
    input  logic      wb_valid,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output word_t     result
);

    // Operands after forwarding
    word_t  src_a;
    word_t  src_b;
    // ALU operand B after the immediate mux
    word_t  alu_b;
    word_t  alu_out;
    word_t  shift_out;
    shamt_t shift_amt;
    logic   hit_a;
    logic   hit_b;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding from WB
    ////////////////////////////////////////////////////////////////////////////

    // WB is the only stage ahead of EX
    // $0 never forwards
    assign hit_a = wb_valid && (wb_rd != '0) && (wb_rd == rs_addr);
    assign hit_b = wb_valid && (wb_rd != '0) && (wb_rd == rt_addr);
    assign src_a = hit_a ? wb_data : op_a;
    assign src_b = hit_b ? wb_data : op_b;

    // I-types replace rt with the extended immediate
    assign alu_b = b_sel_imm ? imm_ext : src_b;

    // ALU
    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_out = src_a + alu_b;
            ALU_SUB:  alu_out = src_a - alu_b;
            ALU_AND:  alu_out = src_a & alu_b;
            ALU_OR:   alu_out = src_a | alu_b;
            ALU_XOR:  alu_out = src_a ^ alu_b;
            ALU_NOR:  alu_out = ~(src_a | alu_b);
            ALU_SLT:  alu_out = word_t'($signed(src_a) < $signed(alu_b));
            ALU_SLTU: alu_out = word_t'(src_a < alu_b);
            // Immediate into the upper half
            ALU_LUI:  alu_out = alu_b << 16;
            default:  alu_out = '0;
        endcase
    end

    // Barrel shifter on rt
    // Amount from the instruction or from rs[4:0]
    assign shift_amt = shamt_from_reg ? src_a[$bits(shamt_t)-1:0] : shamt;

    always_comb begin
        case (shift_op)
            SH_SLL:  shift_out = src_b << shift_amt;
            SH_SRL:  shift_out = src_b >> shift_amt;
            // Arithmetic form fills with the sign bit
            SH_SRA:  shift_out = $signed(src_b) >>> shift_amt;
            default: shift_out = src_b;
        endcase
    end

    assign result = (res_sel == RES_SHIFT) ? shift_out : alu_out;

endmodule

// File: pipeline.sv
`timescale 1ns/1ps

module pipeline
    import pipeline_types_pkg::*;
    import pipeline_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  word_t     in_instr,
    input  logic      retire_ready,
    output logic      in_ready,
    output logic      retire_valid,
    output reg_addr_t retire_rd,
    output word_t     retire_data
);

    // Whole pipe moves or holds together
    logic      advance;

    // ID stage latch
    logic      id_valid;
    word_t     id_instr;

    // Decoder and register file outputs
    reg_addr_t dec_rs_addr;
    reg_addr_t dec_rt_addr;
    reg_addr_t dec_rd_addr;
    word_t     dec_imm_ext;
    logic      dec_b_sel_imm;
    alu_op_e   dec_alu_op;
    shift_op_e dec_shift_op;
    logic      dec_shamt_from_reg;
    shamt_t    dec_shamt;
    res_sel_e  dec_res_sel;
    word_t     id_rs_data;
    word_t     id_rt_data;

    // ID/EX register
    logic      ex_valid;
    word_t     ex_op_a;
    word_t     ex_op_b;
    word_t     ex_imm_ext;
    reg_addr_t ex_rs_addr;
    reg_addr_t ex_rt_addr;
    reg_addr_t ex_rd_addr;
    logic      ex_b_sel_imm;
    logic      ex_shamt_from_reg;
    shamt_t    ex_shamt;
    alu_op_e   ex_alu_op;
    shift_op_e ex_shift_op;
    res_sel_e  ex_res_sel;
    word_t     ex_result;

    // EX/WB register
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      wb_write;

    // Stall only when WB holds a result the sink refuses
    assign advance  = !retire_valid || retire_ready;
    assign in_ready = advance;

    ////////////////////////////////////////////////////////////////////////////
    // ID
    ////////////////////////////////////////////////////////////////////////////

    instr_decoder u_decoder (
        .instr          (id_instr),
        .rs_addr        (dec_rs_addr),
        .rt_addr        (dec_rt_addr),
        .rd_addr        (dec_rd_addr),
        .imm_ext        (dec_imm_ext),
        .b_sel_imm      (dec_b_sel_imm),
        .alu_op         (dec_alu_op),
        .shift_op       (dec_shift_op),
        .shamt_from_reg (dec_shamt_from_reg),
        .shamt          (dec_shamt),
        .res_sel        (dec_res_sel)
    );

    // Written by the WB retire and bypassed to this stage's reads
    gpr_file u_gpr (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (dec_rs_addr),
        .rt_addr (dec_rt_addr),
        .w_en    (wb_write),
        .w_addr  (wb_rd),
        .w_data  (wb_data),
        .rs_data (id_rs_data),
        .rt_data (id_rt_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // EX
    ////////////////////////////////////////////////////////////////////////////

    exec_unit u_exec (
        .op_a           (ex_op_a),
        .op_b           (ex_op_b),
        .imm_ext        (ex_imm_ext),
        .rs_addr        (ex_rs_addr),
        .rt_addr        (ex_rt_addr),
        .b_sel_imm      (ex_b_sel_imm),
        .shamt_from_reg (ex_shamt_from_reg),
        .shamt          (ex_shamt),
        .alu_op         (ex_alu_op),
        .shift_op       (ex_shift_op),
        .res_sel        (ex_res_sel),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .result         (ex_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stage registers and WB
    ////////////////////////////////////////////////////////////////////////////

    // Valid bits shift on advance
    // Empty stages carry a cleared valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else if (advance) begin
            id_valid <= in_valid;
            ex_valid <= id_valid;
            wb_valid <= ex_valid;
        end
    end

    // Payload follows its valid bit
    always_ff @(posedge clk) begin
        if (advance) begin
            id_instr          <= in_instr;
            ex_op_a           <= id_rs_data;
            ex_op_b           <= id_rt_data;
            ex_imm_ext        <= dec_imm_ext;
            ex_rs_addr        <= dec_rs_addr;
            ex_rt_addr        <= dec_rt_addr;
            ex_rd_addr        <= dec_rd_addr;
            ex_b_sel_imm      <= dec_b_sel_imm;
            ex_shamt_from_reg <= dec_shamt_from_reg;
            ex_shamt          <= dec_shamt;
            ex_alu_op         <= dec_alu_op;
            ex_shift_op       <= dec_shift_op;
            ex_res_sel        <= dec_res_sel;
            wb_rd             <= ex_rd_addr;
            // Writes to $0 retire as zero
            wb_data           <= (ex_rd_addr == '0) ? '0 : ex_result;
        end
    end

    // Retire port and register write share one handshake
    assign retire_valid = wb_valid;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;
    assign wb_write     = retire_valid && retire_ready;

endmodule

// File: pipeline_asserts.sv
`timescale 1ns/1ps

module pipeline_asserts
    import pipeline_types_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      in_ready,
    input logic      retire_valid,
    input logic      retire_ready,
    input reg_addr_t retire_rd,
    input word_t     retire_data
);

    // Failure tallies per property
    int err_reset = 0;
    int err_hold  = 0;
    int err_zero  = 0;
    int assert_errors;

    assign assert_errors = err_reset + err_hold + err_zero;

    // Pipe leaves reset empty and accepting
    reset_empty: assert property (@(posedge clk) !rst_n |=> !retire_valid && in_ready)
        else begin
            $error("retire_valid or in_ready wrong after reset");
            err_reset++;
        end

    // Refused retire keeps its payload
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && !retire_ready
        |=> retire_valid && $stable(retire_rd) && $stable(retire_data))
        else begin
            $error("retire outputs changed while stalled");
            err_hold++;
        end

    // $0 always retires as zero
    zero_dest: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && (retire_rd == '0) |-> retire_data == '0)
        else begin
            $error("nonzero data retired to register 0");
            err_zero++;
        end

endmodule

// File: pipeline_checker.sv
`timescale 1ns/1ps

module pipeline_checker
    import pipeline_types_pkg::*;
    import pipeline_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  logic      in_ready,
    input  word_t     in_instr,
    input  logic      retire_valid,
    input  logic      retire_ready,
    input  reg_addr_t retire_rd,
    input  word_t     retire_data,
    output int        value_errors,
    output int        other_errors,
    output int        accepted,
    output int        retired,
    output int        pending
);

    // Architectural register model with entry 0 held at zero
    word_t     model [REG_COUNT];

    // Expected retires in accept order
    reg_addr_t exp_rd_q [$];
    word_t     exp_data_q [$];

    reg_addr_t want_rd;
    word_t     want_data;

    // Two's complement compare from the sign bits
    function automatic logic signed_less(input word_t x, input word_t y);
        logic lt;
        if (x[31] != y[31])
            lt = x[31];
        else
            lt = x < y;
        return lt;
    endfunction

    // Right shift with the vacated bits set to the old sign
    function automatic word_t shift_right_arith(input word_t x, input logic [4:0] amt);
        word_t res;
        res = x >> amt;
        if (x[31])
            res = res | ~(32'hffff_ffff >> amt);
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference result from the ISA rules
    ////////////////////////////////////////////////////////////////////////////

    function automatic void predict(input word_t instr, output reg_addr_t rd,
                                    output word_t data);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] sa;
        word_t      a;
        word_t      b;
        word_t      simm;
        word_t      zimm;
        op   = instr[31:26];
        fn   = instr[5:0];
        sa   = instr[10:6];
        a    = model[instr[25:21]];
        b    = model[instr[20:16]];
        simm = {{16{instr[15]}}, instr[15:0]};
        zimm = {16'h0000, instr[15:0]};
        // Anything unrecognized lands on $0
        rd   = '0;
        data = '0;
        if (op == OP_SPECIAL) begin
            rd = instr[15:11];
            case (fn)
                FN_ADDU: data = a + b;
                FN_SUBU: data = a - b;
                FN_AND:  data = a & b;
                FN_OR:   data = a | b;
                FN_XOR:  data = a ^ b;
                FN_NOR:  data = ~(a | b);
                FN_SLT:  data = {31'd0, signed_less(a, b)};
                FN_SLTU: data = {31'd0, a < b};
                FN_SLL:  data = b << sa;
                FN_SRL:  data = b >> sa;
                FN_SRA:  data = shift_right_arith(b, sa);
                // Variable shifts use rs[4:0]
                FN_SLLV: data = b << a[4:0];
                FN_SRLV: data = b >> a[4:0];
                FN_SRAV: data = shift_right_arith(b, a[4:0]);
                default: rd = '0;
            endcase
        end else begin
            // I-types write rt
            rd = instr[20:16];
            case (op)
                OP_ADDIU: data = a + simm;
                OP_SLTI:  data = {31'd0, signed_less(a, simm)};
                OP_ANDI:  data = a & zimm;
                OP_ORI:   data = a | zimm;
                OP_XORI:  data = a ^ zimm;
                OP_LUI:   data = {instr[15:0], 16'h0000};
                default:  rd = '0;
            endcase
        end
        if (rd == '0)
            data = '0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Accept and retire tracking
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++)
                model[i] = '0;
            exp_rd_q.delete();
            exp_data_q.delete();
            value_errors = 0;
            other_errors = 0;
            accepted     = 0;
            retired      = 0;
        end else begin
            // Retire compares against the oldest outstanding instruction
            if (retire_valid && retire_ready) begin
                if (exp_rd_q.size() == 0) begin
                    $display("Retire seen at %0t with no accepted instruction outstanding",
                             $time);
                    other_errors++;
                end else begin
                    want_rd   = exp_rd_q.pop_front();
                    want_data = exp_data_q.pop_front();
                    if (retire_rd !== want_rd) begin
                        $display("CHECK FAILED: retire_rd got 0x%02h expected 0x%02h (retire %0d)",
                                 retire_rd, want_rd, retired);
                        value_errors++;
                    end
                    if (retire_data !== want_data) begin
                        $display("CHECK FAILED: retire_data got 0x%08h expected 0x%08h (retire %0d)",
                                 retire_data, want_data, retired);
                        value_errors++;
                    end
                end
                retired++;
            end
            // Model advances in program order on each accept
            if (in_valid && in_ready) begin
                predict(in_instr, want_rd, want_data);
                if (want_rd != '0)
                    model[want_rd] = want_data;
                exp_rd_q.push_back(want_rd);
                exp_data_q.push_back(want_data);
                accepted++;
            end
        end
        pending = exp_rd_q.size();
    end

endmodule

// File: tb_pipeline.sv
`timescale 1ns/1ps

module tb_pipeline
    import pipeline_types_pkg::*;
    import pipeline_isa_pkg::*;
();

    localparam int CLK_PERIOD     = 20;
    localparam int NUM_INSTR      = 2000;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 20;
    localparam int SEED           = 94961;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    word_t     in_instr;
    logic      in_ready;
    logic      retire_valid;
    logic      retire_ready;
    reg_addr_t retire_rd;
    word_t     retire_data;

    // Counts from the checker
    int value_errors;
    int other_errors;
    int accepted;
    int retired;
    int pending;
    int tb_errors;
    int total_errors;
    int hold_left;

    pipeline u_pipeline (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .retire_ready (retire_ready),
        .in_ready     (in_ready),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    pipeline_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_instr     (in_instr),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .value_errors (value_errors),
        .other_errors (other_errors),
        .accepted     (accepted),
        .retired      (retired),
        .pending      (pending)
    );

    bind pipeline pipeline_asserts u_asserts (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_ready     (in_ready),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random instruction generation
    ////////////////////////////////////////////////////////////////////////////

    // Mostly a few hot registers so results feed each other
    function automatic reg_addr_t pick_reg();
        int r;
        r = $urandom_range(99);
        if (r < 10)
            return '0;
        else if (r < 80)
            return reg_addr_t'($urandom_range(4, 1));
        return reg_addr_t'($urandom_range(31));
    endfunction

    function automatic word_t random_instr();
        int         kind;
        logic [5:0] fn;
        logic [5:0] op;
        kind = $urandom_range(99);
        if (kind < 55) begin
            case ($urandom_range(13))
                0:       fn = FN_ADDU;
                1:       fn = FN_SUBU;
                2:       fn = FN_AND;
                3:       fn = FN_OR;
                4:       fn = FN_XOR;
                5:       fn = FN_NOR;
                6:       fn = FN_SLT;
                7:       fn = FN_SLTU;
                8:       fn = FN_SLL;
                9:       fn = FN_SRL;
                10:      fn = FN_SRA;
                11:      fn = FN_SLLV;
                12:      fn = FN_SRLV;
                default: fn = FN_SRAV;
            endcase
            return {OP_SPECIAL, pick_reg(), pick_reg(), pick_reg(), 5'($urandom), fn};
        end else if (kind < 95) begin
            case ($urandom_range(5))
                0:       op = OP_ADDIU;
                1:       op = OP_SLTI;
                2:       op = OP_ANDI;
                3:       op = OP_ORI;
                4:       op = OP_XORI;
                default: op = OP_LUI;
            endcase
            return {op, pick_reg(), pick_reg(), 16'($urandom)};
        end else if (kind < 98) begin
            // lw, sw, beq, addi are outside the kept subset
            case ($urandom_range(3))
                0:       op = 6'h23;
                1:       op = 6'h2b;
                2:       op = 6'h04;
                default: op = 6'h08;
            endcase
            return {op, 26'($urandom)};
        end
        // jr, add, syscall functs
        case ($urandom_range(2))
            0:       fn = 6'h08;
            1:       fn = 6'h20;
            default: fn = 6'h0c;
        endcase
        return {OP_SPECIAL, 20'($urandom), fn};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Input stream driving
    ////////////////////////////////////////////////////////////////////////////

    // Idle cycles with junk on the data lines
    task automatic insert_gap();
        int gap;
        gap = ($urandom_range(99) < 25) ? $urandom_range(3, 1) : 0;
        repeat (gap) begin
            @(negedge clk);
            in_valid = 1'b0;
            in_instr = $urandom;
        end
    endtask

    // Holds the word until the pipe takes it
    task automatic send_instr(input word_t instr);
        @(negedge clk);
        in_valid = 1'b1;
        in_instr = instr;
        @(posedge clk);
        while (!in_ready)
            @(posedge clk);
    endtask

    // Retire back-pressure with about 30% low cycles and occasional long stalls
    initial begin
        hold_left = 0;
        forever begin
            @(negedge clk);
            if (hold_left > 0) begin
                retire_ready = 1'b0;
                hold_left--;
            end else if ($urandom_range(99) < 3) begin
                hold_left    = $urandom_range(10, 4);
                retire_ready = 1'b0;
            end else begin
                retire_ready = ($urandom_range(99) >= 30);
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_instr     = '0;
        retire_ready = 1'b0;
        tb_errors    = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_INSTR; i++) begin
            insert_gap();
            send_instr(random_instr());
        end
        @(negedge clk);
        in_valid = 1'b0;

        // Drain, then give stray retires a chance to show up
        while (retired < NUM_INSTR)
            @(negedge clk);
        repeat (10) @(negedge clk);

        if (pending != 0 || accepted != NUM_INSTR || retired != NUM_INSTR) begin
            $display("Instruction count mismatch: accepted %0d, retired %0d, outstanding %0d",
                     accepted, retired, pending);
            tb_errors++;
        end

        total_errors = value_errors + other_errors + tb_errors
                     + u_pipeline.u_asserts.assert_errors;
        $display("Errors: value %0d, protocol %0d, assertion %0d, testbench %0d (retired %0d)",
                 value_errors, other_errors, u_pipeline.u_asserts.assert_errors, tb_errors,
                 retired);
        if (total_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: pipeline.f
pipeline_types_pkg.sv
pipeline_isa_pkg.sv
instr_decoder.sv
gpr_file.sv
exec_unit.sv
pipeline.sv
pipeline_asserts.sv
pipeline_checker.sv
tb_pipeline.sv

// File: Makefile
# Sources come from the file list so the binary tracks every edit
SRCS := $(shell cat pipeline.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_pipeline: $(SRCS) pipeline.f
	verilator --binary --timing --assert --top-module tb_pipeline -f pipeline.f

# The error limit keeps assertion failures from ending the run early
run: obj_dir/Vtb_pipeline
	./obj_dir/Vtb_pipeline +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "Run failed, see sim.log"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
